// ==== vlog.f ====
src/pcie_user_pkg.sv
src/ppfifo.sv
src/axis_to_ppfifo.sv
src/ppfifo_to_axis.sv
src/pcie_channel_mux.sv
src/bar_addr_reader.sv
src/pcie_user_interface.sv
tests/pcie_user_interface_assert.sv
tests/tb_pcie_user_interface.sv

// ==== tests/tb_pcie_user_interface.sv ====
// ====================
// Testbench for the PCIe user interface
// Table-driven receive and transmit packets, a config-space model,
// random transmit back-pressure and a BAR read at the end
// ====================
module tb_pcie_user_interface import pcie_user_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int    CMD_DEPTH   = 4;
  localparam int    DATA_DEPTH  = 6;
  localparam int    TIMEOUT     = 200;
  localparam word_t CFG_BASE    = 32'h1000_0000;
  localparam word_t DATA_OFFSET = 32'h0001_0000;

  typedef enum {DIR_RX, DIR_TX} dir_e;
  typedef enum {CH_CMD, CH_DATA, CH_BOTH, CH_NONE} chan_e;
  typedef struct {
    string name;
    dir_e  dir;
    chan_e chan;
    int    count;
    word_t base;
    bit    rand_bp;
  } row_t;

  logic clk, i_rst;
  logic i_rx_valid, i_rx_last, o_rx_ready;
  word_t i_rx_data;
  bar_hit_t i_rx_bar_hit;
  logic o_tx_valid, o_tx_last, i_tx_ready;
  word_t o_tx_data;
  keep_t o_tx_keep;
  logic o_cfg_rd_en, i_cfg_rd_wr_done, i_read_bar_stb, o_bar_busy;
  logic [9:0] o_cfg_dwaddr;
  word_t i_cfg_do;
  bar_addrs_t o_bar_addr;
  logic i_cmd_in_rd_stb, o_cmd_in_rd_ready, i_cmd_in_rd_activate;
  logic i_data_in_rd_stb, o_data_in_rd_ready, i_data_in_rd_activate;
  logic [SIZE_WIDTH-1:0] o_cmd_in_rd_count, o_data_in_rd_count;
  logic [SIZE_WIDTH-1:0] o_cmd_out_wr_size, o_data_out_wr_size;
  word_t o_cmd_in_rd_data, o_data_in_rd_data, i_cmd_out_wr_data, i_data_out_wr_data;
  ppfifo_sel_t o_cmd_out_wr_ready, i_cmd_out_wr_activate;
  ppfifo_sel_t o_data_out_wr_ready, i_data_out_wr_activate;
  logic i_cmd_out_wr_stb, i_data_out_wr_stb;

  row_t        rows [9];
  word_t       exp_data_q [$];
  bit          exp_last_q [$];
  word_t       mon_word;
  bit          mon_last;
  string       cur_name;
  int          errors;
  int          afails;
  int          tx_mode;
  int          cfg_wait;
  logic [31:0] lcg_state;

  pcie_user_interface #(
    .CMD_FIFO_DEPTH(CMD_DEPTH),
    .DATA_FIFO_DEPTH(DATA_DEPTH)
  ) dut_i (.*);

  always #5 clk = ~clk;

  function automatic logic [31:0] next_random(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic report_mismatch(input string what, input logic [31:0] exp,
                                 input logic [31:0] act);
    errors++;
    $display("MISMATCH %s %s expected %h actual %h", cur_name, what, exp, act);
  endtask

  // Transmit ready is held low in mode 0, high in mode 1 and random in mode 2
  always @(posedge clk) begin
    #1;
    if (tx_mode == 2) begin
      lcg_state  = next_random(lcg_state);
      i_tx_ready = lcg_state[16];
    end else begin
      i_tx_ready = (tx_mode == 1);
    end
  end

  // Config space answers two cycles into each read
  always @(posedge clk) begin
    #1;
    if (o_cfg_rd_en && !i_cfg_rd_wr_done) begin
      if (cfg_wait == 2) begin
        i_cfg_rd_wr_done = 1'b1;
        i_cfg_do         = CFG_BASE + o_cfg_dwaddr * 16;
        cfg_wait         = 0;
      end else begin
        cfg_wait++;
      end
    end else begin
      i_cfg_rd_wr_done = 1'b0;
      cfg_wait         = 0;
    end
  end

  // Transmit scoreboard samples mid-cycle
  always @(negedge clk) begin
    if (!i_rst && o_tx_valid && i_tx_ready) begin
      if (exp_data_q.size() == 0) begin
        errors++;
        $display("ERROR: %s: transmit word %h arrived with none expected", cur_name, o_tx_data);
      end else begin
        mon_word = exp_data_q.pop_front();
        mon_last = exp_last_q.pop_front();
        if (o_tx_data !== mon_word) report_mismatch("tx data", mon_word, o_tx_data);
        if (o_tx_last !== mon_last) report_mismatch("tx last", mon_last, o_tx_last);
        if (o_tx_keep !== 4'hf) report_mismatch("tx keep", 4'hf, o_tx_keep);
      end
    end
  end

  task automatic send_packet(input chan_e chan, input int count, input word_t base);
    bar_hit_t hit;
    int       waited;
    hit = '0;
    if (chan == CH_CMD || chan == CH_BOTH) hit[CMD_SELECT] = 1'b1;
    if (chan == CH_DATA || chan == CH_BOTH) hit[DATA_SELECT] = 1'b1;
    if (chan == CH_NONE) hit[4] = 1'b1;
    for (int i = 0; i < count; i++) begin
      i_rx_valid   = 1'b1;
      i_rx_data    = base + i;
      i_rx_last    = (i == count - 1);
      i_rx_bar_hit = hit;
      waited       = 0;
      #1;
      while (!o_rx_ready && waited < TIMEOUT) begin
        @(posedge clk);
        #2;
        waited++;
      end
      if (!o_rx_ready) begin
        errors++;
        $display("ERROR: %s: receive word %0d was never accepted", cur_name, i);
        i_rx_valid = 1'b0;
        return;
      end
      @(posedge clk);
      #1;
    end
    i_rx_valid = 1'b0;
    i_rx_last  = 1'b0;
  endtask

  task automatic read_ingress(input bit is_cmd, input int count, input word_t base);
    int waited;
    waited = 0;
    while (!(is_cmd ? o_cmd_in_rd_ready : o_data_in_rd_ready) && waited < TIMEOUT) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (!(is_cmd ? o_cmd_in_rd_ready : o_data_in_rd_ready)) begin
      errors++;
      $display("ERROR: %s: ingress buffer never became ready", cur_name);
      return;
    end
    if (is_cmd) i_cmd_in_rd_activate = 1'b1;
    else i_data_in_rd_activate = 1'b1;
    if ((is_cmd ? o_cmd_in_rd_count : o_data_in_rd_count) !== count)
      report_mismatch("rd count", count, is_cmd ? o_cmd_in_rd_count : o_data_in_rd_count);
    for (int i = 0; i < count; i++) begin
      if ((is_cmd ? o_cmd_in_rd_data : o_data_in_rd_data) !== base + i)
        report_mismatch("rd data", base + i, is_cmd ? o_cmd_in_rd_data : o_data_in_rd_data);
      i_cmd_in_rd_stb  = is_cmd;
      i_data_in_rd_stb = !is_cmd;
      @(posedge clk);
      #1;
      i_cmd_in_rd_stb  = 1'b0;
      i_data_in_rd_stb = 1'b0;
    end
    i_cmd_in_rd_activate  = 1'b0;
    i_data_in_rd_activate = 1'b0;
    @(posedge clk);
    #1;
  endtask

  task automatic expect_quiet_ingress(input int cycles);
    for (int i = 0; i < cycles; i++) begin
      if (o_cmd_in_rd_ready || o_data_in_rd_ready) begin
        errors++;
        $display("ERROR: %s: an unexpected packet showed up in an ingress FIFO", cur_name);
        return;
      end
      @(posedge clk);
      #1;
    end
  endtask

  // Fill one egress buffer per channel in lockstep so both commit together
  task automatic stage_egress(input chan_e chan, input int count, input word_t base);
    bit use_cmd;
    bit use_data;
    bit blocked;
    int waited;
    use_cmd  = (chan == CH_CMD || chan == CH_BOTH);
    use_data = (chan == CH_DATA || chan == CH_BOTH);
    waited   = 0;
    blocked  = (use_cmd && o_cmd_out_wr_ready == '0) || (use_data && o_data_out_wr_ready == '0);
    while (blocked && waited < TIMEOUT) begin
      @(posedge clk);
      #1;
      waited++;
      blocked = (use_cmd && o_cmd_out_wr_ready == '0) ||
                (use_data && o_data_out_wr_ready == '0);
    end
    if (blocked) begin
      errors++;
      $display("ERROR: %s: no free egress buffer to write", cur_name);
      return;
    end
    if (use_cmd) i_cmd_out_wr_activate = o_cmd_out_wr_ready[0] ? 2'b01 : 2'b10;
    if (use_data) i_data_out_wr_activate = o_data_out_wr_ready[0] ? 2'b01 : 2'b10;
    for (int i = 0; i < count; i++) begin
      i_cmd_out_wr_stb   = use_cmd;
      i_cmd_out_wr_data  = base + i;
      i_data_out_wr_stb  = use_data;
      i_data_out_wr_data = base + DATA_OFFSET + i;
      @(posedge clk);
      #1;
    end
    i_cmd_out_wr_stb       = 1'b0;
    i_data_out_wr_stb      = 1'b0;
    i_cmd_out_wr_activate  = '0;
    i_data_out_wr_activate = '0;
    // Command packet leaves first when both wait
    for (int i = 0; i < count && use_cmd; i++) begin
      exp_data_q.push_back(base + i);
      exp_last_q.push_back(i == count - 1);
    end
    for (int i = 0; i < count && use_data; i++) begin
      exp_data_q.push_back(base + DATA_OFFSET + i);
      exp_last_q.push_back(i == count - 1);
    end
  endtask

  task automatic drain_transmit(input bit rand_bp);
    int waited;
    waited = 0;
    #2;
    tx_mode = rand_bp ? 2 : 1;
    while (exp_data_q.size() != 0 && waited < TIMEOUT) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (exp_data_q.size() != 0) begin
      errors++;
      $display("ERROR: %s: %0d transmit words never came out", cur_name, exp_data_q.size());
      exp_data_q.delete();
      exp_last_q.delete();
    end
    #2;
    tx_mode = 0;
    @(posedge clk);
    #1;
  endtask

  task automatic read_bars();
    int waited;
    word_t exp;
    i_read_bar_stb = 1'b1;
    @(posedge clk);
    #1;
    i_read_bar_stb = 1'b0;
    waited = 0;
    while (o_bar_busy && waited < TIMEOUT) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (o_bar_busy || waited == 0) begin
      errors++;
      $display("ERROR: %s: BAR read did not run to completion", cur_name);
    end
    for (int n = 0; n < NUM_BARS; n++) begin
      exp = CFG_BASE + (BAR0_DWADDR + n) * 16;
      if (o_bar_addr[n] !== exp) report_mismatch($sformatf("bar %0d", n), exp, o_bar_addr[n]);
    end
  endtask

  initial begin
    clk = 1'b0;
    i_rst = 1'b1;
    {i_rx_valid, i_rx_last, i_tx_ready, i_cfg_rd_wr_done, i_read_bar_stb} = '0;
    {i_cmd_in_rd_stb, i_cmd_in_rd_activate, i_data_in_rd_stb, i_data_in_rd_activate} = '0;
    {i_cmd_out_wr_stb, i_data_out_wr_stb} = '0;
    i_rx_data = '0;
    i_rx_bar_hit = '0;
    i_cfg_do = '0;
    i_cmd_out_wr_activate = '0;
    i_data_out_wr_activate = '0;
    i_cmd_out_wr_data = '0;
    i_data_out_wr_data = '0;
    tx_mode = 0;
    cfg_wait = 0;
    lcg_state = 32'h5ae7;
    errors = 0;
    cur_name = "reset";
    rows = '{
      '{"cmd_short",    DIR_RX, CH_CMD,  5,  32'hC000_0010, 1'b0},
      '{"data_pkt",     DIR_RX, CH_DATA, 7,  32'hD000_0020, 1'b0},
      '{"both_bits",    DIR_RX, CH_BOTH, 4,  32'hB000_0030, 1'b0},
      '{"no_bits",      DIR_RX, CH_NONE, 3,  32'hE000_0040, 1'b0},
      '{"cmd_full",     DIR_RX, CH_CMD,  16, 32'hC100_0050, 1'b0},
      '{"tx_pair",      DIR_TX, CH_BOTH, 4,  32'hA000_0100, 1'b0},
      '{"tx_cmd_rand",  DIR_TX, CH_CMD,  6,  32'hA100_0200, 1'b1},
      '{"tx_pair_rand", DIR_TX, CH_BOTH, 5,  32'hA200_0300, 1'b1},
      '{"tx_data_rand", DIR_TX, CH_DATA, 9,  32'hA300_0400, 1'b1}
    };
    repeat (8) @(posedge clk);
    #1;
    if (o_rx_ready !== 1'b0) report_mismatch("rx_ready", 0, o_rx_ready);
    if (o_tx_valid !== 1'b0) report_mismatch("tx_valid", 0, o_tx_valid);
    if (o_cfg_rd_en !== 1'b0) report_mismatch("cfg_rd_en", 0, o_cfg_rd_en);
    if (o_bar_busy !== 1'b0) report_mismatch("bar_busy", 0, o_bar_busy);
    if (o_bar_addr !== '0) report_mismatch("bar addr", 0, o_bar_addr[0]);
    i_rst = 1'b0;
    @(posedge clk);
    #1;
    cur_name = "sizes";
    if (o_cmd_out_wr_size !== 2 ** CMD_DEPTH)
      report_mismatch("cmd wr size", 2 ** CMD_DEPTH, o_cmd_out_wr_size);
    if (o_data_out_wr_size !== 2 ** DATA_DEPTH)
      report_mismatch("data wr size", 2 ** DATA_DEPTH, o_data_out_wr_size);
    // Both egress buffers start out empty
    if (o_cmd_out_wr_ready !== 2'b11)
      report_mismatch("cmd wr ready", 2'b11, o_cmd_out_wr_ready);
    if (o_data_out_wr_ready !== 2'b11)
      report_mismatch("data wr ready", 2'b11, o_data_out_wr_ready);
    foreach (rows[r]) begin
      cur_name = rows[r].name;
      if (rows[r].dir == DIR_RX) begin
        send_packet(rows[r].chan, rows[r].count, rows[r].base);
        if (rows[r].chan == CH_NONE) expect_quiet_ingress(20);
        else read_ingress(rows[r].chan != CH_DATA, rows[r].count, rows[r].base);
      end else begin
        stage_egress(rows[r].chan, rows[r].count, rows[r].base);
        drain_transmit(rows[r].rand_bp);
      end
    end
    cur_name = "bar_read";
    read_bars();
    cur_name = "final_idle";
    expect_quiet_ingress(5);
    afails = dut_i.assert_i.fail_count;
    $display("Done: %0d check errors, %0d assertion failures", errors, afails);
    if (errors == 0 && afails == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== tests/pcie_user_interface_assert.sv ====
// ====================
// Concurrent checks on the stream, ping-pong and config read handshakes
// Bound into every instance of the interface top level
// ====================
module pcie_user_interface_assert import pcie_user_pkg::*; (
  input logic        clk,
  input logic        i_rst,
  input logic        i_rx_valid,
  input word_t       i_rx_data,
  input logic        i_rx_last,
  input bar_hit_t    i_rx_bar_hit,
  input logic        o_rx_ready,
  input logic        o_tx_valid,
  input word_t       o_tx_data,
  input logic        o_tx_last,
  input logic        i_tx_ready,
  input logic        o_cfg_rd_en,
  input logic        i_cfg_rd_wr_done,
  input ppfifo_sel_t i_cmd_out_wr_activate,
  input ppfifo_sel_t i_data_out_wr_activate,
  input ppfifo_sel_t c_in_act,
  input ppfifo_sel_t d_in_act
);
  timeunit 1ns;
  timeprecision 1ps;

  int fail_count = 0;

  // Stream words stay put until taken
  rx_hold: assert property (@(posedge clk) disable iff (i_rst)
    i_rx_valid && !o_rx_ready |=> i_rx_valid && $stable(i_rx_data) &&
      $stable(i_rx_last) && $stable(i_rx_bar_hit))
    else begin
      fail_count++;
      $error("receive word changed or dropped before it was accepted");
    end

  tx_hold: assert property (@(posedge clk) disable iff (i_rst)
    o_tx_valid && !i_tx_ready |=> o_tx_valid && $stable(o_tx_data) && $stable(o_tx_last))
    else begin
      fail_count++;
      $error("transmit word changed or dropped before it was taken");
    end

  // Only one buffer per writer at a time
  act_onehot: assert property (@(posedge clk) disable iff (i_rst)
    $onehot0(c_in_act) && $onehot0(d_in_act) &&
      $onehot0(i_cmd_out_wr_activate) && $onehot0(i_data_out_wr_activate))
    else begin
      fail_count++;
      $error("a ping-pong activate vector has more than one bit set");
    end

  cfg_hold: assert property (@(posedge clk) disable iff (i_rst)
    o_cfg_rd_en && !i_cfg_rd_wr_done |=> o_cfg_rd_en)
    else begin
      fail_count++;
      $error("config read enable dropped before done");
    end

endmodule

bind pcie_user_interface pcie_user_interface_assert assert_i (
  .clk(clk), .i_rst(i_rst), .i_rx_valid(i_rx_valid), .i_rx_data(i_rx_data),
  .i_rx_last(i_rx_last), .i_rx_bar_hit(i_rx_bar_hit), .o_rx_ready(o_rx_ready),
  .o_tx_valid(o_tx_valid), .o_tx_data(o_tx_data), .o_tx_last(o_tx_last),
  .i_tx_ready(i_tx_ready), .o_cfg_rd_en(o_cfg_rd_en),
  .i_cfg_rd_wr_done(i_cfg_rd_wr_done), .i_cmd_out_wr_activate(i_cmd_out_wr_activate),
  .i_data_out_wr_activate(i_data_out_wr_activate), .c_in_act(c_in_act),
  .d_in_act(d_in_act)
);

// ==== src/pcie_user_interface.sv ====
// ====================
// User-side PCIe packet interface
// Receive stream lands in command or data ingress FIFOs by BAR hit
// Egress FIFOs are merged onto the transmit stream, BARs read on request
// ====================
module pcie_user_interface import pcie_user_pkg::*; #(
  parameter int CMD_FIFO_DEPTH  = 4,
  parameter int DATA_FIFO_DEPTH = 6
)(
  input  logic                  clk,
  input  logic                  i_rst,
  input  logic                  i_rx_valid,
  input  word_t                 i_rx_data,
  input  logic                  i_rx_last,
  input  bar_hit_t              i_rx_bar_hit,
  output logic                  o_rx_ready,
  output logic                  o_tx_valid,
  output word_t                 o_tx_data,
  output keep_t                 o_tx_keep,
  output logic                  o_tx_last,
  input  logic                  i_tx_ready,
  output logic                  o_cfg_rd_en,
  output logic [9:0]            o_cfg_dwaddr,
  input  word_t                 i_cfg_do,
  input  logic                  i_cfg_rd_wr_done,
  input  logic                  i_read_bar_stb,
  output bar_addrs_t            o_bar_addr,
  output logic                  o_bar_busy,
  input  logic                  i_cmd_in_rd_stb,
  output logic                  o_cmd_in_rd_ready,
  input  logic                  i_cmd_in_rd_activate,
  output logic [SIZE_WIDTH-1:0] o_cmd_in_rd_count,
  output word_t                 o_cmd_in_rd_data,
  output ppfifo_sel_t           o_cmd_out_wr_ready,
  input  ppfifo_sel_t           i_cmd_out_wr_activate,
  output logic [SIZE_WIDTH-1:0] o_cmd_out_wr_size,
  input  logic                  i_cmd_out_wr_stb,
  input  word_t                 i_cmd_out_wr_data,
  input  logic                  i_data_in_rd_stb,
  output logic                  o_data_in_rd_ready,
  input  logic                  i_data_in_rd_activate,
  output logic [SIZE_WIDTH-1:0] o_data_in_rd_count,
  output word_t                 o_data_in_rd_data,
  output ppfifo_sel_t           o_data_out_wr_ready,
  input  ppfifo_sel_t           i_data_out_wr_activate,
  output logic [SIZE_WIDTH-1:0] o_data_out_wr_size,
  input  logic                  i_data_out_wr_stb,
  input  word_t                 i_data_out_wr_data
);

  // Receive side after steering
  word_t                 chan_rx_data;
  logic                  chan_rx_last;
  logic                  c_rx_valid, c_rx_ready, d_rx_valid, d_rx_ready;

  // Ingress FIFO write sides
  ppfifo_sel_t           c_in_rdy, c_in_act, d_in_rdy, d_in_act;
  logic [SIZE_WIDTH-1:0] c_in_size, d_in_size;
  logic                  c_in_stb, d_in_stb;
  word_t                 c_in_data, d_in_data;

  // Egress FIFO read sides
  logic                  c_out_rdy, c_out_act, c_out_stb;
  logic                  d_out_rdy, d_out_act, d_out_stb;
  logic [SIZE_WIDTH-1:0] c_out_count, d_out_count;
  word_t                 c_out_data, d_out_data;

  // Egress streams into the arbiter
  logic                  c_tx_valid, c_tx_last, c_tx_ready;
  logic                  d_tx_valid, d_tx_last, d_tx_ready;
  word_t                 c_tx_data, d_tx_data;

  pcie_channel_mux mux_i (
    .clk(clk), .i_rst(i_rst),
    .i_rx_valid(i_rx_valid), .i_rx_data(i_rx_data), .i_rx_last(i_rx_last),
    .i_rx_bar_hit(i_rx_bar_hit), .o_rx_ready(o_rx_ready),
    .o_chan_rx_data(chan_rx_data), .o_chan_rx_last(chan_rx_last),
    .o_cmd_rx_valid(c_rx_valid), .o_data_rx_valid(d_rx_valid),
    .i_cmd_rx_ready(c_rx_ready), .i_data_rx_ready(d_rx_ready),
    .i_cmd_tx_valid(c_tx_valid), .i_cmd_tx_data(c_tx_data), .i_cmd_tx_last(c_tx_last),
    .i_data_tx_valid(d_tx_valid), .i_data_tx_data(d_tx_data), .i_data_tx_last(d_tx_last),
    .o_cmd_tx_ready(c_tx_ready), .o_data_tx_ready(d_tx_ready),
    .o_tx_valid(o_tx_valid), .o_tx_data(o_tx_data), .o_tx_keep(o_tx_keep),
    .o_tx_last(o_tx_last), .i_tx_ready(i_tx_ready)
  );

  // Command channel
  axis_to_ppfifo cmd_a2p_i (
    .clk(clk), .i_rst(i_rst),
    .i_axi_valid(c_rx_valid), .i_axi_data(chan_rx_data), .i_axi_last(chan_rx_last),
    .o_axi_ready(c_rx_ready),
    .i_ppfifo_rdy(c_in_rdy), .i_ppfifo_size(c_in_size), .o_ppfifo_act(c_in_act),
    .o_ppfifo_stb(c_in_stb), .o_ppfifo_data(c_in_data)
  );

  ppfifo #(.ADDR_WIDTH(CMD_FIFO_DEPTH)) cmd_ingress_i (
    .clk(clk), .i_rst(i_rst),
    .i_wr_activate(c_in_act), .i_wr_stb(c_in_stb), .i_wr_data(c_in_data),
    .o_wr_ready(c_in_rdy), .o_wr_size(c_in_size),
    .i_rd_activate(i_cmd_in_rd_activate), .i_rd_stb(i_cmd_in_rd_stb),
    .o_rd_ready(o_cmd_in_rd_ready), .o_rd_count(o_cmd_in_rd_count),
    .o_rd_data(o_cmd_in_rd_data)
  );

  ppfifo #(.ADDR_WIDTH(CMD_FIFO_DEPTH)) cmd_egress_i (
    .clk(clk), .i_rst(i_rst),
    .i_wr_activate(i_cmd_out_wr_activate), .i_wr_stb(i_cmd_out_wr_stb),
    .i_wr_data(i_cmd_out_wr_data),
    .o_wr_ready(o_cmd_out_wr_ready), .o_wr_size(o_cmd_out_wr_size),
    .i_rd_activate(c_out_act), .i_rd_stb(c_out_stb),
    .o_rd_ready(c_out_rdy), .o_rd_count(c_out_count), .o_rd_data(c_out_data)
  );

  ppfifo_to_axis cmd_p2a_i (
    .clk(clk), .i_rst(i_rst),
    .i_ppfifo_rdy(c_out_rdy), .i_ppfifo_size(c_out_count), .i_ppfifo_data(c_out_data),
    .o_ppfifo_act(c_out_act), .o_ppfifo_stb(c_out_stb),
    .i_axi_ready(c_tx_ready), .o_axi_valid(c_tx_valid), .o_axi_data(c_tx_data),
    .o_axi_last(c_tx_last)
  );

  // Data channel
  axis_to_ppfifo data_a2p_i (
    .clk(clk), .i_rst(i_rst),
    .i_axi_valid(d_rx_valid), .i_axi_data(chan_rx_data), .i_axi_last(chan_rx_last),
    .o_axi_ready(d_rx_ready),
    .i_ppfifo_rdy(d_in_rdy), .i_ppfifo_size(d_in_size), .o_ppfifo_act(d_in_act),
    .o_ppfifo_stb(d_in_stb), .o_ppfifo_data(d_in_data)
  );

  ppfifo #(.ADDR_WIDTH(DATA_FIFO_DEPTH)) data_ingress_i (
    .clk(clk), .i_rst(i_rst),
    .i_wr_activate(d_in_act), .i_wr_stb(d_in_stb), .i_wr_data(d_in_data),
    .o_wr_ready(d_in_rdy), .o_wr_size(d_in_size),
    .i_rd_activate(i_data_in_rd_activate), .i_rd_stb(i_data_in_rd_stb),
    .o_rd_ready(o_data_in_rd_ready), .o_rd_count(o_data_in_rd_count),
    .o_rd_data(o_data_in_rd_data)
  );

  ppfifo #(.ADDR_WIDTH(DATA_FIFO_DEPTH)) data_egress_i (
    .clk(clk), .i_rst(i_rst),
    .i_wr_activate(i_data_out_wr_activate), .i_wr_stb(i_data_out_wr_stb),
    .i_wr_data(i_data_out_wr_data),
    .o_wr_ready(o_data_out_wr_ready), .o_wr_size(o_data_out_wr_size),
    .i_rd_activate(d_out_act), .i_rd_stb(d_out_stb),
    .o_rd_ready(d_out_rdy), .o_rd_count(d_out_count), .o_rd_data(d_out_data)
  );

  ppfifo_to_axis data_p2a_i (
    .clk(clk), .i_rst(i_rst),
    .i_ppfifo_rdy(d_out_rdy), .i_ppfifo_size(d_out_count), .i_ppfifo_data(d_out_data),
    .o_ppfifo_act(d_out_act), .o_ppfifo_stb(d_out_stb),
    .i_axi_ready(d_tx_ready), .o_axi_valid(d_tx_valid), .o_axi_data(d_tx_data),
    .o_axi_last(d_tx_last)
  );

  bar_addr_reader bar_reader_i (
    .clk(clk), .i_rst(i_rst), .i_read_bar_stb(i_read_bar_stb),
    .o_cfg_rd_en(o_cfg_rd_en), .o_cfg_dwaddr(o_cfg_dwaddr),
    .i_cfg_do(i_cfg_do), .i_cfg_rd_wr_done(i_cfg_rd_wr_done),
    .o_bar_addr(o_bar_addr), .o_bar_busy(o_bar_busy)
  );

endmodule

// ==== src/bar_addr_reader.sv ====
// ====================
// Reads the six BAR base addresses from configuration space
// Start with a strobe, wait for busy to fall, then read the addresses
// ====================
module bar_addr_reader import pcie_user_pkg::*; (
  input  logic       clk,
  input  logic       i_rst,
  input  logic       i_read_bar_stb,
  output logic       o_cfg_rd_en,
  output logic [9:0] o_cfg_dwaddr,
  input  word_t      i_cfg_do,
  input  logic       i_cfg_rd_wr_done,
  output bar_addrs_t o_bar_addr,
  output logic       o_bar_busy
);

  localparam int IDX_WIDTH = $clog2(NUM_BARS);

  logic [IDX_WIDTH-1:0] idx;

  assign o_cfg_dwaddr = 10'(BAR0_DWADDR) + 10'(idx);

  always_ff @(posedge clk) begin
    if (i_rst) begin
      o_cfg_rd_en <= 1'b0;
      o_bar_busy  <= 1'b0;
      o_bar_addr  <= '0;
      idx         <= '0;
    end else if (o_bar_busy) begin
      if (!o_cfg_rd_en) begin
        o_cfg_rd_en <= 1'b1;
      end else if (i_cfg_rd_wr_done) begin
        // One idle cycle between requests so each read starts fresh
        o_cfg_rd_en     <= 1'b0;
        o_bar_addr[idx] <= i_cfg_do;
        if (idx == IDX_WIDTH'(NUM_BARS - 1)) begin
          o_bar_busy <= 1'b0;
        end else begin
          idx <= idx + 1'b1;
        end
      end
    end else if (i_read_bar_stb) begin
      o_bar_busy <= 1'b1;
      idx        <= '0;
    end
  end

endmodule

// ==== src/pcie_channel_mux.sv ====
// ====================
// Receive steering by BAR hit and transmit arbiter for two channels
// Command wins when idle; a grant holds until the packet's last word
// ====================
module pcie_channel_mux import pcie_user_pkg::*; (
  input  logic     clk,
  input  logic     i_rst,
  input  logic     i_rx_valid,
  input  word_t    i_rx_data,
  input  logic     i_rx_last,
  input  bar_hit_t i_rx_bar_hit,
  output logic     o_rx_ready,
  output word_t    o_chan_rx_data,
  output logic     o_chan_rx_last,
  output logic     o_cmd_rx_valid,
  output logic     o_data_rx_valid,
  input  logic     i_cmd_rx_ready,
  input  logic     i_data_rx_ready,
  input  logic     i_cmd_tx_valid,
  input  word_t    i_cmd_tx_data,
  input  logic     i_cmd_tx_last,
  input  logic     i_data_tx_valid,
  input  word_t    i_data_tx_data,
  input  logic     i_data_tx_last,
  output logic     o_cmd_tx_ready,
  output logic     o_data_tx_ready,
  output logic     o_tx_valid,
  output word_t    o_tx_data,
  output keep_t    o_tx_keep,
  output logic     o_tx_last,
  input  logic     i_tx_ready
);

  logic       cmd_hit;
  logic       data_hit;
  logic [1:0] grant;

  // Command bit has priority over data bit
  assign cmd_hit  = i_rx_bar_hit[CMD_SELECT];
  assign data_hit = !cmd_hit && i_rx_bar_hit[DATA_SELECT];

  assign o_chan_rx_data  = i_rx_data;
  assign o_chan_rx_last  = i_rx_last;
  assign o_cmd_rx_valid  = i_rx_valid && cmd_hit;
  assign o_data_rx_valid = i_rx_valid && data_hit;

  // Words with no channel bit are swallowed as soon as they show up
  assign o_rx_ready = cmd_hit  ? i_cmd_rx_ready  :
                      data_hit ? i_data_rx_ready : i_rx_valid;

  assign o_tx_valid = grant[CMD_SELECT]  ? i_cmd_tx_valid  :
                      grant[DATA_SELECT] ? i_data_tx_valid : 1'b0;
  assign o_tx_data  = grant[DATA_SELECT] ? i_data_tx_data  : i_cmd_tx_data;
  assign o_tx_last  = grant[DATA_SELECT] ? i_data_tx_last  : i_cmd_tx_last;
  assign o_tx_keep  = '1;

  assign o_cmd_tx_ready  = grant[CMD_SELECT]  && i_tx_ready;
  assign o_data_tx_ready = grant[DATA_SELECT] && i_tx_ready;

  always_ff @(posedge clk) begin
    if (i_rst) begin
      grant <= '0;
    end else if (grant == '0) begin
      if (i_cmd_tx_valid) begin
        grant[CMD_SELECT] <= 1'b1;
      end else if (i_data_tx_valid) begin
        grant[DATA_SELECT] <= 1'b1;
      end
    end else if (o_tx_valid && i_tx_ready && o_tx_last) begin
      grant <= '0;
    end
  end

endmodule

// ==== src/ppfifo_to_axis.sv ====
// ====================
// Ping-pong FIFO to stream reader
// Each committed buffer goes out as one packet, last on its final word
// ====================
module ppfifo_to_axis import pcie_user_pkg::*; (
  input  logic                  clk,
  input  logic                  i_rst,
  input  logic                  i_ppfifo_rdy,
  input  logic [SIZE_WIDTH-1:0] i_ppfifo_size,
  input  word_t                 i_ppfifo_data,
  output logic                  o_ppfifo_act,
  output logic                  o_ppfifo_stb,
  input  logic                  i_axi_ready,
  output logic                  o_axi_valid,
  output word_t                 o_axi_data,
  output logic                  o_axi_last
);

  logic [SIZE_WIDTH-1:0] count;
  logic                  xfer;

  // FIFO read data falls through, so it stays put until the next strobe
  assign o_axi_valid  = o_ppfifo_act && (count < i_ppfifo_size);
  assign o_axi_data   = i_ppfifo_data;
  assign o_axi_last   = (count + 1'b1 == i_ppfifo_size);
  assign xfer         = o_axi_valid && i_axi_ready;
  assign o_ppfifo_stb = xfer;

  always_ff @(posedge clk) begin
    if (i_rst) begin
      o_ppfifo_act <= 1'b0;
      count        <= '0;
    end else if (!o_ppfifo_act) begin
      count <= '0;
      if (i_ppfifo_rdy) begin
        o_ppfifo_act <= 1'b1;
      end
    end else if (xfer) begin
      count <= count + 1'b1;
      // Release the buffer once its last word is gone
      if (o_axi_last) begin
        o_ppfifo_act <= 1'b0;
      end
    end
  end

endmodule

// ==== src/axis_to_ppfifo.sv ====
// ====================
// Stream to ping-pong FIFO writer
// Fills free buffers word by word and commits on last or when full
// ====================
module axis_to_ppfifo import pcie_user_pkg::*; (
  input  logic                  clk,
  input  logic                  i_rst,
  input  logic                  i_axi_valid,
  input  word_t                 i_axi_data,
  input  logic                  i_axi_last,
  output logic                  o_axi_ready,
  input  ppfifo_sel_t           i_ppfifo_rdy,
  input  logic [SIZE_WIDTH-1:0] i_ppfifo_size,
  output ppfifo_sel_t           o_ppfifo_act,
  output logic                  o_ppfifo_stb,
  output word_t                 o_ppfifo_data
);

  logic [SIZE_WIDTH-1:0] count;
  logic                  closing;
  logic                  xfer;

  // Closing waits one cycle so the final strobe lands before commit
  assign o_axi_ready = (o_ppfifo_act != '0) && !closing;
  assign xfer        = i_axi_valid && o_axi_ready;

  always_ff @(posedge clk) begin
    if (i_rst) begin
      o_ppfifo_act <= '0;
      o_ppfifo_stb <= 1'b0;
      closing      <= 1'b0;
      count        <= '0;
    end else begin
      o_ppfifo_stb <= 1'b0;
      if (o_ppfifo_act == '0) begin
        count   <= '0;
        closing <= 1'b0;
        if (i_ppfifo_rdy[0]) begin
          o_ppfifo_act <= 2'b01;
        end else if (i_ppfifo_rdy[1]) begin
          o_ppfifo_act <= 2'b10;
        end
      end else if (closing) begin
        o_ppfifo_act <= '0;
      end else if (xfer) begin
        o_ppfifo_stb <= 1'b1;
        count        <= count + 1'b1;
        if (i_axi_last || (count + 1'b1 == i_ppfifo_size)) begin
          closing <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (xfer) begin
      o_ppfifo_data <= i_axi_data;
    end
  end

endmodule

// ==== src/ppfifo.sv ====
// ====================
// Single-clock ping-pong FIFO with two buffers
// Writer activates a ready buffer, strobes words and drops activate to commit
// Reader activates, strobes through the count and drops activate to release
// ====================
module ppfifo import pcie_user_pkg::*; #(
  parameter int ADDR_WIDTH = 4
)(
  input  logic                  clk,
  input  logic                  i_rst,
  input  ppfifo_sel_t           i_wr_activate,
  input  logic                  i_wr_stb,
  input  word_t                 i_wr_data,
  output ppfifo_sel_t           o_wr_ready,
  output logic [SIZE_WIDTH-1:0] o_wr_size,
  input  logic                  i_rd_activate,
  input  logic                  i_rd_stb,
  output logic                  o_rd_ready,
  output logic [SIZE_WIDTH-1:0] o_rd_count,
  output word_t                 o_rd_data
);

  localparam int DEPTH = 2 ** ADDR_WIDTH;

  word_t                 mem [2][DEPTH];
  logic [ADDR_WIDTH:0]   wr_count [2];
  logic [1:0]            committed;
  ppfifo_sel_t           wr_act_q;
  logic                  rd_act_q;
  logic                  rd_sel;
  logic [ADDR_WIDTH-1:0] rd_ptr;
  logic                  wr_sel;
  logic                  wr_en;

  assign wr_sel = i_wr_activate[1];
  assign wr_en  = i_wr_stb && i_wr_activate[wr_sel] &&
                  (wr_count[wr_sel] < (ADDR_WIDTH + 1)'(DEPTH));

  // A buffer is free once released and no longer held by the writer
  assign o_wr_ready[0] = !committed[0] && !wr_act_q[0];
  assign o_wr_ready[1] = !committed[1] && !wr_act_q[1];
  assign o_wr_size     = SIZE_WIDTH'(DEPTH);

  // Fall-through read of the buffer handed to the reader
  assign o_rd_ready = committed[rd_sel] && !rd_act_q;
  assign o_rd_count = SIZE_WIDTH'(wr_count[rd_sel]);
  assign o_rd_data  = mem[rd_sel][rd_ptr];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_sel][wr_count[wr_sel][ADDR_WIDTH-1:0]] <= i_wr_data;
    end
  end

  always_ff @(posedge clk) begin
    if (i_rst) begin
      wr_act_q    <= '0;
      rd_act_q    <= 1'b0;
      committed   <= '0;
      rd_sel      <= 1'b0;
      rd_ptr      <= '0;
      wr_count[0] <= '0;
      wr_count[1] <= '0;
    end else begin
      wr_act_q <= i_wr_activate;
      rd_act_q <= i_rd_activate;
      if (wr_en) begin
        wr_count[wr_sel] <= wr_count[wr_sel] + 1'b1;
      end
      // Falling activate commits; an empty buffer simply becomes free again
      for (int i = 0; i < 2; i++) begin
        if (wr_act_q[i] && !i_wr_activate[i] && (wr_count[i] != '0)) begin
          committed[i] <= 1'b1;
          if (!committed[1-i]) begin
            rd_sel <= i[0];
          end
        end
      end
      if (!i_rd_activate) begin
        rd_ptr <= '0;
      end else if (i_rd_stb) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // Release hands the other buffer to the reader next
      if (rd_act_q && !i_rd_activate) begin
        committed[rd_sel] <= 1'b0;
        wr_count[rd_sel]  <= '0;
        rd_sel            <= ~rd_sel;
      end
    end
  end

endmodule

// ==== src/pcie_user_pkg.sv ====
// ====================
// Shared types and constants for the PCIe user-side packet interface
// Every RTL module that carries words, BAR data or sizes imports this
// ====================
package pcie_user_pkg;

  localparam int SIZE_WIDTH = 24;
  localparam int NUM_BARS   = 6;

  // BAR-hit bits that pick a channel
  localparam int CMD_SELECT  = 0;
  localparam int DATA_SELECT = 1;

  // Config space dword holding BAR 0
  localparam int BAR0_DWADDR = 4;

  typedef logic [31:0] word_t;
  typedef logic [3:0]  keep_t;
  typedef logic [6:0]  bar_hit_t;
  typedef logic [31:0] bar_addr_t;
  typedef bar_addr_t [NUM_BARS-1:0] bar_addrs_t;

  // One bit per ping-pong buffer
  typedef logic [1:0] ppfifo_sel_t;

endpackage
